//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_ex_top -Mdir obj_dir \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_ex_top > sim.log 2>&1
cat sim.log

! grep -q "Regression failed" sim.log && grep -q "Regression passed" sim.log \
    && exit 0 || { echo "simulation reported failure"; exit 1; }

//--- sim/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected results of the single-cycle datapath
function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
    dword_t p;
    case (op)
        OR: return a | b;
        NOR: return ~(a | b);
        AND: return a & b;
        XOR: return a ^ b;
        SLL: return a << b[4:0];
        SRL: return a >> b[4:0];
        SRA: return word_t'($signed(a) >>> b[4:0]);
        ADD: return a + b;
        SUB: return a - b;
        SLT: return {31'b0, $signed(a) < $signed(b)};
        SLTU: return {31'b0, a < b};
        MUL: return a * b;
        MULH: begin
            p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            return p[63:32];
        end
        MULHU: begin
            p = {32'b0, a} * {32'b0, b};
            return p[63:32];
        end
        default: return '0;
    endcase
endfunction

// divide by zero gives all ones and keeps the dividend as remainder
function automatic word_t model_div(alu_op_t op, word_t a, word_t b);
    word_t q;
    word_t r;
    if (b == '0) begin
        q = '1;
        r = a;
    end else if (op == DIV || op == MOD) begin
        if (a == 32'h8000_0000 && b == '1) begin
            q = a;   // overflow wraps
            r = '0;
        end else begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
    end else begin
        q = a / b;
        r = a % b;
    end
    return (op == MOD || op == MODU) ? r : q;
endfunction

function automatic word_t model_addr(alu_op_t op, word_t r1, word_t r2, word_t inst);
    case (op)
        STB, STH, STW: return r1 + {{20{inst[21]}}, inst[21:10]};
        SCW: return r1 + {{16{inst[23]}}, inst[23:10], 2'b00};
        default: return r1 + r2;
    endcase
endfunction

function automatic mem_size_t model_size(alu_op_t op);
    case (op)
        LDB, LDBU, STB: return SIZE_B;
        LDH, LDHU, STH: return SIZE_H;
        default: return SIZE_W;
    endcase
endfunction

function automatic wb_sel_t model_sel(mem_size_t size, word_t addr);
    case (size)
        SIZE_B: return wb_sel_t'(4'b0001 << addr[1:0]);
        SIZE_H: return addr[1] ? 4'b1100 : 4'b0011;
        default: return 4'b1111;
    endcase
endfunction

function automatic logic model_misaligned(mem_size_t size, word_t addr);
    return ((size == SIZE_H) && addr[0]) || ((size == SIZE_W) && (addr[1:0] != 2'b00));
endfunction

function automatic word_t model_load(alu_op_t op, word_t w, word_t addr);
    word_t lane;
    lane = w >> (8 * addr[1:0]);
    case (op)
        LDB: return {{24{lane[7]}}, lane[7:0]};
        LDBU: return {24'b0, lane[7:0]};
        LDH: return {{16{lane[15]}}, lane[15:0]};
        LDHU: return {16'b0, lane[15:0]};
        default: return w;
    endcase
endfunction

// merge store data into a memory word under the byte strobes
function automatic word_t model_store(word_t w, word_t d, mem_size_t size, word_t addr);
    word_t rep;
    wb_sel_t sel;
    rep = (size == SIZE_B) ? {4{d[7:0]}} : (size == SIZE_H) ? {2{d[15:0]}} : d;
    sel = model_sel(size, addr);
    for (int b = 0; b < 4; b++) begin
        if (sel[b]) w[8*b +: 8] = rep[8*b +: 8];
    end
    return w;
endfunction

`endif

//--- sim/tb_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;
    import ex_isa_pkg::*;
    import ex_mem_pkg::*;

    `include "ex_ref_model.svh"

    // worst-case cycles per test with three wait states for every memory op
    localparam int MEM_CYC = 10;
    localparam int LIMIT = 2 * (60 * 2 + 21 * 36 + 56 * MEM_CYC + 5 * 4 + 4 * MEM_CYC
                                + 30 * MEM_CYC + 256) + 20;

    logic clk, rst, in_valid, in_ready, out_valid, out_ale;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    alu_op_t in_op;
    word_t in_reg1, in_reg2, in_inst, out_data, wb_wdata, wb_rdata;
    wb_addr_t wb_adr;
    wb_sel_t wb_sel, last_sel;

    word_t mem [256];
    word_t model_mem [256];
    logic [15:0] lfsr_stim, lfsr_wait;
    logic ll_model, in_bus, cyc_seen;
    int wait_left, writes, checks, errors, cycles;

    ex_top #(.WB_ADDR_W(32)) ex_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t rand_bits(inout logic [15:0] st, input int n);
        word_t r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = st[15] ^ st[13] ^ st[12] ^ st[10];   // x^16 + x^14 + x^13 + x^11 + 1
            st = {st[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t fill_word(int i);
        return {8'(i), 8'(~i), 8'(i * 37), 8'(i ^ 8'h5a)};
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_sel(string name, wb_sel_t exp, wb_sel_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    // the wishbone memory answers on the falling edge like the issue port
    always @(negedge clk) begin
        if (wb_cyc) cyc_seen = 1'b1;
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!in_bus) begin
                in_bus = 1'b1;
                wait_left = int'(rand_bits(lfsr_wait, 2));
            end
            if (wait_left == 0) begin
                if (wb_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel[b]) mem[wb_adr[9:2]][8*b +: 8] = wb_wdata[8*b +: 8];
                    end
                    last_sel = wb_sel;
                    writes++;
                end
                wb_rdata = mem[wb_adr[9:2]];
                wb_ack = 1'b1;
                in_bus = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: no result after %0d cycles, run stopped", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // one operation from acceptance to its result strobe with the latency in cycles
    task automatic issue(alu_op_t op, word_t r1, word_t r2, word_t inst,
                         output word_t data, output logic ale, output int lat);
        check_flag("in_ready", 1'b1, in_ready);
        in_valid = 1'b1;
        in_op = op;
        in_reg1 = r1;
        in_reg2 = r2;
        in_inst = inst;
        @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
        lat = 1;
        while (!out_valid) begin
            check_flag("in_ready", 1'b0, in_ready);
            @(negedge clk);
            lat++;
        end
        data = out_data;
        ale = out_ale;
    endtask

    // builds operands that reach addr, predicts the outcome and checks it
    task automatic run_mem(alu_op_t op, word_t addr, word_t d);
        word_t r1, r2, inst, exp, got, a;
        logic ale, bad, store, wr;
        int lat, w0;
        mem_size_t sz;
        r2 = d;
        inst = rand_bits(lfsr_stim, 32);
        if (op == SCW) begin
            r1 = addr - {{16{inst[23]}}, inst[23:10], 2'b00};
        end else if (op == STB || op == STH || op == STW) begin
            r1 = addr - {{20{inst[21]}}, inst[21:10]};
        end else begin
            r2 = rand_bits(lfsr_stim, 32);
            r1 = addr - r2;
        end
        a = model_addr(op, r1, r2, inst);
        sz = model_size(op);
        bad = model_misaligned(sz, a);
        store = (op == STB || op == STH || op == STW || op == SCW);
        exp = '0;
        wr = 1'b0;
        if (!bad && !(op == SCW && !ll_model)) begin
            if (store) begin
                model_mem[a[9:2]] = model_store(model_mem[a[9:2]], d, sz, a);
                exp = (op == SCW) ? 32'd1 : '0;
                wr = 1'b1;
                if (op == SCW) ll_model = 1'b0;
            end else begin
                exp = model_load(op, model_mem[a[9:2]], a);
                if (op == LLW) ll_model = 1'b1;
            end
        end
        cyc_seen = 1'b0;
        w0 = writes;
        issue(op, r1, r2, inst, got, ale, lat);
        check_word("out_data", exp, got);
        check_flag("out_ale", bad, ale);
        if (bad) begin
            repeat (2) @(negedge clk);   // a stray bus cycle would be visible by now
            check_flag("wb_cyc", 1'b0, cyc_seen);
            check_count("latency", 1, lat);
        end
        check_count("write count", wr ? w0 + 1 : w0, writes);
        if (wr) begin
            check_sel("wb_sel", model_sel(sz, a), last_sel);
        end
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 256; i++) check_word($sformatf("mem[%0d]", i), model_mem[i], mem[i]);
    endtask

    task automatic end_test(string name, int err0);
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    function automatic word_t rand_addr(mem_size_t sz);
        word_t a;
        a = rand_bits(lfsr_stim, 8) << 2;
        if (sz == SIZE_B) a[1:0] = 2'(rand_bits(lfsr_stim, 2));
        if (sz == SIZE_H) a[1] = 1'(rand_bits(lfsr_stim, 1));
        return a;
    endfunction

    alu_op_t alu_ops [14] = '{OR, NOR, AND, XOR, SLL, SRL, SRA, ADD, SUB, SLT, SLTU,
                              MUL, MULH, MULHU};
    alu_op_t div_ops [4] = '{DIV, DIVU, MOD, MODU};
    alu_op_t st_ops [3] = '{STB, STH, STW};
    alu_op_t ld_ops [5] = '{LDB, LDBU, LDH, LDHU, LDW};

    initial begin
        alu_op_t op;
        word_t a, b, got;
        word_t addrs [$];
        logic ale;
        int lat, err0;
        lfsr_stim = 16'd46462;
        lfsr_wait = 16'd46462;
        {rst, in_valid, wb_ack, in_bus, ll_model, cyc_seen} = 6'b100000;
        {in_op, in_reg1, in_reg2, in_inst, wb_rdata, last_sel} = '0;
        {writes, checks, errors, cycles, wait_left} = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag("in_ready", 1'b1, in_ready);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("wb_cyc", 1'b0, wb_cyc);

        // ==========================================================================
        err0 = errors;
        for (int i = 0; i < 60; i++) begin
            op = alu_ops[rand_bits(lfsr_stim, 4) % 14];
            a = rand_bits(lfsr_stim, 32);
            b = rand_bits(lfsr_stim, 32);
            issue(op, a, b, rand_bits(lfsr_stim, 32), got, ale, lat);
            check_word("out_data", model_alu(op, a, b), got);
            check_count("latency", 1, lat);
        end
        end_test("single_cycle", err0);

        err0 = errors;
        for (int i = 0; i < 21; i++) begin
            op = div_ops[rand_bits(lfsr_stim, 2)];
            a = rand_bits(lfsr_stim, 32);
            b = rand_bits(lfsr_stim, 32);
            b = b >> rand_bits(lfsr_stim, 5);
            if (i % 5 == 4) begin
                b = '0;
            end else if (i % 5 == 2) begin
                b = -b;   // negative divisor
            end
            if (i == 20) begin
                op = DIV;   // most negative over minus one
                a = 32'h8000_0000;
                b = '1;
            end
            issue(op, a, b, '0, got, ale, lat);
            check_word("out_data", model_div(op, a, b), got);
            check_count("latency", 35, lat);
        end
        end_test("divide", err0);

        // ==========================================================================
        err0 = errors;
        for (int i = 0; i < 16; i++) begin
            op = st_ops[rand_bits(lfsr_stim, 2) % 3];
            a = rand_addr(model_size(op));
            addrs.push_back(a);
            run_mem(op, a, rand_bits(lfsr_stim, 32));
        end
        for (int i = 0; i < 40; i++) begin
            op = ld_ops[i % 5];
            a = addrs[i % 16] & ~word_t'(model_size(op) == SIZE_W ? 3 : model_size(op));
            run_mem(op, a, '0);
        end
        compare_memory();
        end_test("store_load", err0);

        err0 = errors;
        run_mem(LDH, 32'h0000_0011, '0);
        run_mem(LDW, 32'h0000_0022, '0);
        run_mem(STH, 32'h0000_0033, 32'h1234_5678);
        run_mem(STW, 32'h0000_0041, 32'h1234_5678);
        run_mem(SCW, 32'h0000_0052, 32'h1234_5678);
        end_test("misaligned", err0);

        err0 = errors;
        run_mem(LLW, 32'h0000_0100, '0);
        run_mem(SCW, 32'h0000_0100, 32'hcafe_0001);
        run_mem(SCW, 32'h0000_0100, 32'hcafe_0002);
        run_mem(SCW, 32'h0000_0104, 32'hcafe_0003);
        check_word("mem[64]", 32'hcafe_0001, mem[64]);
        check_word("mem[65]", model_mem[65], mem[65]);
        end_test("ll_sc", err0);

        err0 = errors;
        for (int i = 0; i < 30; i++) begin
            op = rand_bits(lfsr_stim, 1) ? st_ops[rand_bits(lfsr_stim, 2) % 3]
                                         : ld_ops[rand_bits(lfsr_stim, 3) % 5];
            run_mem(op, rand_addr(model_size(op)), rand_bits(lfsr_stim, 32));
        end
        compare_memory();
        end_test("wait_states", err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+sim
verilog/ex_isa_pkg.sv
verilog/ex_mem_pkg.sv
verilog/ex_div_if.sv
verilog/ex_mem_if.sv
verilog/ex.sv
verilog/ex_divider.sv
verilog/ex_lsu_wb.sv
verilog/ex_top.sv
sim/tb_ex_top.sv

//--- verilog/ex.sv
`timescale 1ns/1ps
`default_nettype none

module ex #(
    parameter int WB_ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  ex_isa_pkg::alu_op_t in_op,
    input  ex_isa_pkg::word_t   in_reg1,
    input  ex_isa_pkg::word_t   in_reg2,
    input  ex_isa_pkg::word_t   in_inst,
    output logic                in_ready,
    output logic                out_valid,
    output ex_isa_pkg::word_t   out_data,
    output logic                out_ale,
    ex_div_if.master            div,
    ex_mem_if.master            mem
);
    import ex_isa_pkg::*;
    import ex_mem_pkg::*;

    localparam wb_addr_t ADDR_MASK = wb_addr_t'((64'd1 << WB_ADDR_W) - 64'd1);

    typedef enum logic [1:0] {IDLE, DIV_WAIT, MEM_WAIT} state_t;

    state_t    state;
    logic      ll_bit;
    logic      pick_rem;   // modulo takes the remainder half
    logic      is_sc;
    res_sel_t  res_sel;
    logic      sub_op;
    word_t     sum;
    logic      slt;
    logic      mul_signed;
    word_t     mul_a;
    word_t     mul_b;
    dword_t    mul_mag;
    dword_t    mul_res;
    word_t     alu_res;
    wb_addr_t  addr;
    mem_size_t size;
    logic      misaligned;
    logic      is_store;
    wb_sel_t   strobe;
    word_t     wdata;

    assign res_sel = op_sel(in_op);
    assign in_ready = (state == IDLE);

    // =========================================================================
    // single-cycle datapath
    // =========================================================================
    assign sub_op = (in_op == SUB) || (in_op == SLT);
    assign sum = in_reg1 + (sub_op ? ~in_reg2 + 32'd1 : in_reg2);
    assign slt = (in_reg1[31] && !in_reg2[31]) || ((in_reg1[31] == in_reg2[31]) && sum[31]);

    // multiply the magnitudes, then put the sign back
    assign mul_signed = (in_op == MUL) || (in_op == MULH);
    assign mul_a = (mul_signed && in_reg1[31]) ? -in_reg1 : in_reg1;
    assign mul_b = (mul_signed && in_reg2[31]) ? -in_reg2 : in_reg2;
    assign mul_mag = dword_t'(mul_a) * dword_t'(mul_b);
    assign mul_res = (mul_signed && (in_reg1[31] ^ in_reg2[31])) ? -mul_mag : mul_mag;

    always_comb begin
        case (in_op)
            OR: alu_res = in_reg1 | in_reg2;
            NOR: alu_res = ~(in_reg1 | in_reg2);
            AND: alu_res = in_reg1 & in_reg2;
            XOR: alu_res = in_reg1 ^ in_reg2;
            SLL: alu_res = in_reg1 << in_reg2[4:0];
            SRL: alu_res = in_reg1 >> in_reg2[4:0];
            SRA: alu_res = ({32{in_reg1[31]}} << (6'd32 - {1'b0, in_reg2[4:0]}))
                           | (in_reg1 >> in_reg2[4:0]);   // fill mask over the top bits
            ADD, SUB: alu_res = sum;
            SLT: alu_res = {31'b0, slt};
            SLTU: alu_res = {31'b0, in_reg1 < in_reg2};
            MUL: alu_res = mul_res[31:0];
            MULH, MULHU: alu_res = mul_res[63:32];
            default: alu_res = '0;
        endcase
    end

    // =========================================================================
    // address, strobes and alignment
    // =========================================================================
    always_comb begin
        case (in_op)
            STB, STH, STW: addr = in_reg1 + {{20{in_inst[21]}}, in_inst[21:10]};
            SCW: addr = in_reg1 + {{16{in_inst[23]}}, in_inst[23:10], 2'b00};
            default: addr = in_reg1 + in_reg2;
        endcase
    end

    always_comb begin
        case (in_op)
            LDB, LDBU, STB: size = SIZE_B;
            LDH, LDHU, STH: size = SIZE_H;
            default: size = SIZE_W;
        endcase
    end

    always_comb begin
        case (size)
            SIZE_B: begin
                strobe = wb_sel_t'(4'b0001 << addr[1:0]);
                wdata = {4{in_reg2[7:0]}};
            end
            SIZE_H: begin
                strobe = addr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{in_reg2[15:0]}};
            end
            default: begin
                strobe = 4'b1111;
                wdata = in_reg2;
            end
        endcase
    end

    assign misaligned = ((size == SIZE_H) && addr[0])
                        || ((size == SIZE_W) && (addr[1:0] != 2'b00));
    assign is_store = (in_op == STB) || (in_op == STH) || (in_op == STW) || (in_op == SCW);

    // =========================================================================
    // issue control and result register
    // =========================================================================
    always_ff @(posedge clk) begin
        out_valid <= 1'b0;
        out_ale <= 1'b0;
        div.start <= 1'b0;
        mem.req <= 1'b0;
        if (rst) begin
            state <= IDLE;
            ll_bit <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_valid) begin
                        if (res_sel == SEL_DIV) begin
                            div.start <= 1'b1;
                            div.signed_op <= (in_op == DIV) || (in_op == MOD);
                            div.dividend <= in_reg1;
                            div.divisor <= in_reg2;
                            pick_rem <= (in_op == MOD) || (in_op == MODU);
                            state <= DIV_WAIT;
                        end else if (res_sel == SEL_MEM && misaligned) begin
                            out_valid <= 1'b1;   // ALE, no bus cycle
                            out_ale <= 1'b1;
                            out_data <= '0;
                        end else if (in_op == SCW && !ll_bit) begin
                            out_valid <= 1'b1;
                            out_data <= '0;
                        end else if (res_sel == SEL_MEM) begin
                            mem.req <= 1'b1;
                            mem.we <= is_store;
                            mem.addr <= addr & ADDR_MASK;
                            mem.wdata <= wdata;
                            mem.sel <= strobe;
                            mem.size <= size;
                            mem.sign_ext <= (in_op == LDB) || (in_op == LDH);
                            is_sc <= (in_op == SCW);
                            if (in_op == LLW) begin
                                ll_bit <= 1'b1;
                            end else if (in_op == SCW) begin
                                ll_bit <= 1'b0;   // reservation used up by this store
                            end
                            state <= MEM_WAIT;
                        end else begin
                            out_valid <= 1'b1;
                            out_data <= alu_res;
                        end
                    end
                end
                DIV_WAIT: begin
                    if (div.done) begin
                        out_valid <= 1'b1;
                        out_data <= pick_rem ? div.result[63:32] : div.result[31:0];
                        state <= IDLE;
                    end
                end
                MEM_WAIT: begin
                    if (mem.ack) begin
                        out_valid <= 1'b1;
                        if (is_sc) begin
                            out_data <= 32'd1;
                        end else if (mem.we) begin
                            out_data <= '0;
                        end else begin
                            out_data <= mem.rdata;
                        end
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // only one unit is ever started per accepted operation
    assert property (@(posedge clk) disable iff (rst) !(div.start && mem.req));

endmodule

`default_nettype wire

//--- verilog/ex_div_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_div_if;
    import ex_isa_pkg::*;

    logic   start;
    logic   signed_op;
    word_t  dividend;
    word_t  divisor;
    logic   done;
    dword_t result;   // quotient low, remainder high

    modport master (
        output start, signed_op, dividend, divisor,
        input  done, result
    );

    modport slave (
        input  start, signed_op, dividend, divisor,
        output done, result
    );

endinterface

`default_nettype wire

//--- verilog/ex_divider.sv
`timescale 1ns/1ps
`default_nettype none

module ex_divider (
    input  logic     clk,
    input  logic     rst,
    ex_div_if.slave  div
);
    import ex_isa_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, FIX} state_t;

    state_t      state;
    logic [4:0]  count;
    word_t       quo;   // dividend shifts out as quotient bits shift in
    word_t       rem;
    word_t       dvs;
    logic        neg_q;
    logic        neg_r;
    logic [32:0] trial;

    // shift one dividend bit into the partial remainder and try the subtract
    assign trial = {rem, quo[31]} - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (div.start) begin
                        rem <= '0;
                        quo <= (div.signed_op && div.dividend[31]) ? -div.dividend
                                                                   : div.dividend;
                        dvs <= (div.signed_op && div.divisor[31]) ? -div.divisor
                                                                  : div.divisor;
                        // a zero divisor keeps the all-ones quotient unsigned
                        neg_q <= div.signed_op && (div.dividend[31] ^ div.divisor[31])
                                 && (div.divisor != '0);
                        neg_r <= div.signed_op && div.dividend[31];
                        count <= '0;
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (!trial[32]) begin
                        rem <= trial[31:0];
                        quo <= {quo[30:0], 1'b1};
                    end else begin
                        rem <= {rem[30:0], quo[31]};
                        quo <= {quo[30:0], 1'b0};
                    end
                    count <= count + 5'd1;
                    if (count == 5'd31) begin
                        state <= FIX;
                    end
                end
                default: state <= IDLE;   // fix-up cycle lasts one clock
            endcase
        end
    end

    // signs are applied while done is high
    assign div.done = (state == FIX);
    assign div.result = {neg_r ? -rem : rem, neg_q ? -quo : quo};

    // the stage has to wait for done before it starts the next divide
    assert property (@(posedge clk) disable iff (rst) div.start |-> state == IDLE);

endmodule

`default_nettype wire

//--- verilog/ex_isa_pkg.sv
`default_nettype none

package ex_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [5:0]  alu_op_t;
    typedef logic [2:0]  res_sel_t;

    // operation codes as the decoder hands them to the stage
    localparam alu_op_t OR    = 6'h00;
    localparam alu_op_t NOR   = 6'h01;
    localparam alu_op_t AND   = 6'h02;
    localparam alu_op_t XOR   = 6'h03;
    localparam alu_op_t SLL   = 6'h04;
    localparam alu_op_t SRL   = 6'h05;
    localparam alu_op_t SRA   = 6'h06;
    localparam alu_op_t ADD   = 6'h07;
    localparam alu_op_t SUB   = 6'h08;
    localparam alu_op_t SLT   = 6'h09;
    localparam alu_op_t SLTU  = 6'h0a;
    localparam alu_op_t MUL   = 6'h0b;
    localparam alu_op_t MULH  = 6'h0c;
    localparam alu_op_t MULHU = 6'h0d;
    localparam alu_op_t DIV   = 6'h0e;
    localparam alu_op_t DIVU  = 6'h0f;
    localparam alu_op_t MOD   = 6'h10;
    localparam alu_op_t MODU  = 6'h11;
    localparam alu_op_t LDB   = 6'h12;
    localparam alu_op_t LDBU  = 6'h13;
    localparam alu_op_t LDH   = 6'h14;
    localparam alu_op_t LDHU  = 6'h15;
    localparam alu_op_t LDW   = 6'h16;
    localparam alu_op_t LLW   = 6'h17;
    localparam alu_op_t STB   = 6'h18;
    localparam alu_op_t STH   = 6'h19;
    localparam alu_op_t STW   = 6'h1a;
    localparam alu_op_t SCW   = 6'h1b;

    // which datapath produces the result
    localparam res_sel_t SEL_LOGIC = 3'd0;
    localparam res_sel_t SEL_SHIFT = 3'd1;
    localparam res_sel_t SEL_ARITH = 3'd2;
    localparam res_sel_t SEL_MUL   = 3'd3;
    localparam res_sel_t SEL_DIV   = 3'd4;
    localparam res_sel_t SEL_MEM   = 3'd5;

    function automatic res_sel_t op_sel(alu_op_t op);
        case (op)
            OR, NOR, AND, XOR: return SEL_LOGIC;
            SLL, SRL, SRA: return SEL_SHIFT;
            MUL, MULH, MULHU: return SEL_MUL;
            DIV, DIVU, MOD, MODU: return SEL_DIV;
            LDB, LDBU, LDH, LDHU, LDW, LLW, STB, STH, STW, SCW: return SEL_MEM;
            default: return SEL_ARITH;   // add, sub and the compares
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/ex_lsu_wb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_lsu_wb #(
    parameter int WB_ADDR_W = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  ex_isa_pkg::word_t    wb_rdata,
    input  logic                 wb_ack,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output ex_mem_pkg::wb_addr_t wb_adr,
    output ex_isa_pkg::word_t    wb_wdata,
    output ex_mem_pkg::wb_sel_t  wb_sel,
    ex_mem_if.slave              mem
);
    import ex_isa_pkg::*;
    import ex_mem_pkg::*;

    typedef enum logic {IDLE, BUS} state_t;

    state_t               state;
    logic [WB_ADDR_W-1:0] adr_q;
    mem_size_t            size_q;
    logic                 sign_q;
    word_t                lane;
    word_t                load_ext;

    assign wb_cyc = (state == BUS);
    assign wb_stb = (state == BUS);
    assign wb_adr = wb_addr_t'(adr_q);

    // addressed byte or half moved down to bit 0
    assign lane = wb_rdata >> {adr_q[1:0], 3'b000};

    always_comb begin
        case (size_q)
            SIZE_B: load_ext = {{24{sign_q & lane[7]}}, lane[7:0]};
            SIZE_H: load_ext = {{16{sign_q & lane[15]}}, lane[15:0]};
            default: load_ext = wb_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        mem.ack <= 1'b0;
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (mem.req) begin
                        wb_we <= mem.we;
                        adr_q <= mem.addr[WB_ADDR_W-1:0];
                        wb_wdata <= mem.wdata;
                        wb_sel <= mem.sel;
                        size_q <= mem.size;
                        sign_q <= mem.sign_ext;
                        state <= BUS;
                    end
                end
                BUS: begin
                    if (wb_ack) begin   // cyc and stb drop on the next clock
                        mem.ack <= 1'b1;
                        mem.rdata <= load_ext;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);

endmodule

`default_nettype wire

//--- verilog/ex_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_mem_if;
    import ex_isa_pkg::*;
    import ex_mem_pkg::*;

    logic      req;
    logic      we;
    wb_addr_t  addr;
    word_t     wdata;
    wb_sel_t   sel;
    mem_size_t size;
    logic      sign_ext;
    logic      ack;
    word_t     rdata;   // load data, already extended when ack is high

    modport master (
        output req, we, addr, wdata, sel, size, sign_ext,
        input  ack, rdata
    );

    modport slave (
        input  req, we, addr, wdata, sel, size, sign_ext,
        output ack, rdata
    );

endinterface

`default_nettype wire

//--- verilog/ex_mem_pkg.sv
`default_nettype none

package ex_mem_pkg;

    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = WB_DATA_W / 8;

    typedef logic [1:0]          mem_size_t;
    typedef logic [WB_SEL_W-1:0] wb_sel_t;
    typedef logic [31:0]         wb_addr_t;   // byte address, upper bits may be masked off

    // access size code carried with every request
    localparam mem_size_t SIZE_B = 2'd0;
    localparam mem_size_t SIZE_H = 2'd1;
    localparam mem_size_t SIZE_W = 2'd2;

endpackage

`default_nettype wire

//--- verilog/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top #(
    parameter int WB_ADDR_W = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  ex_isa_pkg::alu_op_t  in_op,
    input  ex_isa_pkg::word_t    in_reg1,
    input  ex_isa_pkg::word_t    in_reg2,
    input  ex_isa_pkg::word_t    in_inst,
    output logic                 in_ready,
    output logic                 out_valid,
    output ex_isa_pkg::word_t    out_data,
    output logic                 out_ale,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output ex_mem_pkg::wb_addr_t wb_adr,
    output ex_isa_pkg::word_t    wb_wdata,
    output ex_mem_pkg::wb_sel_t  wb_sel,
    input  ex_isa_pkg::word_t    wb_rdata,
    input  logic                 wb_ack
);

    ex_div_if div_if_i ();
    ex_mem_if mem_if_i ();

    ex #(
        .WB_ADDR_W (WB_ADDR_W)
    ) ex_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_reg1   (in_reg1),
        .in_reg2   (in_reg2),
        .in_inst   (in_inst),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ale   (out_ale),
        .div       (div_if_i.master),
        .mem       (mem_if_i.master)
    );

    ex_divider ex_divider_i (
        .clk (clk),
        .rst (rst),
        .div (div_if_i.slave)
    );

    ex_lsu_wb #(
        .WB_ADDR_W (WB_ADDR_W)
    ) ex_lsu_wb_i (
        .clk      (clk),
        .rst      (rst),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_sel   (wb_sel),
        .mem      (mem_if_i.slave)
    );

endmodule

`default_nettype wire
